// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = simdCoreTb
FILELIST = sim.f
OUTDIR   = obj_dir
BIN      = $(OUTDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OUTDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OUTDIR)

// ==== hw/laneAlu.sv ====
`timescale 1ns/1ns

module laneAlu (
    input  simdIsaPkg::opClass_t   opClass,
    input  simdDataPkg::laneMode_t laneMode,
    input  logic                   immForm,
    input  simdIsaPkg::immField_t  imm,
    input  simdDataPkg::dataWord_t dstData,
    input  simdDataPkg::dataWord_t srcData,
    output simdDataPkg::dataWord_t aluResult
);
    import simdIsaPkg::*;
    import simdDataPkg::*;

    dataWord_t  wideImm;
    dataWord_t  operandB;
    dataWord_t  bInv;
    dataWord_t  laneSum;
    logic       isSub;
    logic [3:0] carryIn;  // carry into each nibble
    logic [4:0] nibSum [4];

    // immediate replicated across lanes
    always_comb
    begin
        case (laneMode)
            Octet:   wideImm = {2{imm[7:0]}};
            Quad:    wideImm = {4{imm[3:0]}};
            default: wideImm = dataWord_t'(imm);
        endcase
    end

    assign isSub    = (opClass == Sub);
    assign operandB = immForm ? wideImm : srcData;
    assign bInv     = isSub ? ~operandB : operandB;  // a + ~b + 1 per lane

    // 4-bit slices, chain cut where a lane starts
    always_comb
    begin
        carryIn[0] = isSub;
        for (int i = 0; i < 4; i++)
        begin
            nibSum[i] = {1'b0, dstData[4*i +: 4]} + {1'b0, bInv[4*i +: 4]}
                + {4'd0, carryIn[i]};
            laneSum[4*i +: 4] = nibSum[i][3:0];
            if (i < 3)
            begin
                if (laneMode == Quad || (laneMode == Octet && i == 1))
                    carryIn[i+1] = isSub;
                else
                    carryIn[i+1] = nibSum[i][4];
            end
        end
    end

    always_comb
    begin
        case (opClass)
            Add, Sub: aluResult = laneSum;
            And:      aluResult = dstData & srcData;
            Or:       aluResult = dstData | srcData;
            Not:      aluResult = ~srcData;
            Set:      aluResult = wideImm;
            Store:    aluResult = dstData;  // goes out on dataOut
            default:  aluResult = '0;
        endcase
    end

endmodule

// ==== hw/simdCore.sv ====
`timescale 1ns/1ns

module simdCore (
    input  logic                   clk,
    input  logic                   rst,
    input  simdIsaPkg::instrWord_t instructionIn,
    input  simdDataPkg::dataWord_t dataIn,
    output simdDataPkg::dataWord_t dataOut,
    output simdDataPkg::memAddr_t  instructionAddress,
    output simdDataPkg::memAddr_t  dataAddress,
    output logic                   dataRead,
    output logic                   dataWrite,
    output logic                   done
);
    import simdIsaPkg::*;
    import simdDataPkg::*;

    logic      decodeStrobe;
    logic      execStrobe;
    logic      wbStrobe;
    opClass_t  opClass;
    laneMode_t laneMode;
    logic      immForm;
    logic      writesReg;
    regIdx_t   dstIdx;
    regIdx_t   srcIdx;
    immField_t imm;
    dataWord_t dstData;
    dataWord_t srcData;
    dataWord_t aluResult;

    simdSequencer seq_i (
        .clk                (clk),
        .rst                (rst),
        .opClass            (opClass),
        .imm                (imm),
        .decodeStrobe       (decodeStrobe),
        .execStrobe         (execStrobe),
        .wbStrobe           (wbStrobe),
        .instructionAddress (instructionAddress),
        .dataAddress        (dataAddress),
        .dataRead           (dataRead),
        .dataWrite          (dataWrite),
        .done               (done)
    );

    simdDecode decode_i (
        .clk           (clk),
        .rst           (rst),
        .decodeStrobe  (decodeStrobe),
        .instructionIn (instructionIn),
        .opClass       (opClass),
        .laneMode      (laneMode),
        .immForm       (immForm),
        .writesReg     (writesReg),
        .dstIdx        (dstIdx),
        .srcIdx        (srcIdx),
        .imm           (imm)
    );

    laneAlu alu_i (
        .opClass   (opClass),
        .laneMode  (laneMode),
        .immForm   (immForm),
        .imm       (imm),
        .dstData   (dstData),
        .srcData   (srcData),
        .aluResult (aluResult)
    );

    simdRegFiles regs_i (
        .clk        (clk),
        .rst        (rst),
        .execStrobe (execStrobe),
        .wbStrobe   (wbStrobe),
        .opClass    (opClass),
        .laneMode   (laneMode),
        .writesReg  (writesReg),
        .dstIdx     (dstIdx),
        .srcIdx     (srcIdx),
        .aluResult  (aluResult),
        .dataIn     (dataIn),
        .dstData    (dstData),
        .srcData    (srcData),
        .dataOut    (dataOut)
    );

endmodule

// ==== hw/simdDataPkg.sv ====
package simdDataPkg;

    typedef logic [15:0] dataWord_t;
    typedef logic [1:0]  regIdx_t;
    typedef logic [9:0]  memAddr_t;

    typedef enum logic [1:0] {
        Half,
        Octet,
        Quad
    } laneMode_t;

    localparam int NumRegs  = 4;  // per bank
    localparam int NumBanks = 3;  // one per lane mode

    typedef enum logic [2:0] {
        Idle,
        Fetch,
        Decode,
        Execute,
        Memory,
        Writeback,
        Halted
    } seqState_t;

endpackage

// ==== hw/simdDecode.sv ====
`timescale 1ns/1ns

module simdDecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   decodeStrobe,
    input  simdIsaPkg::instrWord_t instructionIn,
    output simdIsaPkg::opClass_t   opClass,
    output simdDataPkg::laneMode_t laneMode,
    output logic                   immForm,
    output logic                   writesReg,
    output simdDataPkg::regIdx_t   dstIdx,
    output simdDataPkg::regIdx_t   srcIdx,
    output simdIsaPkg::immField_t  imm
);
    import simdIsaPkg::*;
    import simdDataPkg::*;

    opcode_t   op;
    opcode_t   base;
    opcode_t   offset;
    opClass_t  cls;
    logic      immSel;
    regIdx_t   dstSel;
    regIdx_t   srcSel;
    regIdx_t   fieldHi;
    regIdx_t   fieldA;
    regIdx_t   fieldB;

    function automatic logic inFamily(opcode_t code, opcode_t familyBase);
        return (code >= familyBase) && (code <= familyBase + 6'd2);
    endfunction

    assign op      = instructionIn[OpcodePos +: $bits(opcode_t)];
    assign fieldHi = instructionIn[DstHiPos +: $bits(regIdx_t)];
    assign fieldA  = instructionIn[SrcAPos +: $bits(regIdx_t)];
    assign fieldB  = instructionIn[SrcBPos +: $bits(regIdx_t)];
    assign offset  = op - base;  // lane mode within the family
    assign immSel  = (base == OpAddImmBase) || (base == OpSubImmBase);

    always_comb
    begin
        cls  = Nop;
        base = '0;
        if (inFamily(op, OpAddRegBase))
            cls = Add;
        else if (inFamily(op, OpAddImmBase))
        begin
            cls  = Add;
            base = OpAddImmBase;
        end
        else if (inFamily(op, OpSubRegBase))
        begin
            cls  = Sub;
            base = OpSubRegBase;
        end
        else if (inFamily(op, OpSubImmBase))
        begin
            cls  = Sub;
            base = OpSubImmBase;
        end
        else if (inFamily(op, OpAndBase))
        begin
            cls  = And;
            base = OpAndBase;
        end
        else if (inFamily(op, OpOrBase))
        begin
            cls  = Or;
            base = OpOrBase;
        end
        else if (inFamily(op, OpNotBase))
        begin
            cls  = Not;
            base = OpNotBase;
        end
        else if (inFamily(op, OpLoadBase))
        begin
            cls  = Load;
            base = OpLoadBase;
        end
        else if (inFamily(op, OpStoreBase))
        begin
            cls  = Store;
            base = OpStoreBase;
        end
        else if (inFamily(op, OpSetBase))
        begin
            cls  = Set;
            base = OpSetBase;
        end
        else if (op == OpLoopJump)
            cls = LoopJump;
        else if (op == OpSetLoop)
            cls = SetLoop;
        else if (op == OpHalt)
            cls = Halt;
    end

    // register fields by class
    always_comb
    begin
        dstSel = fieldHi;
        srcSel = fieldB;
        if (((cls == Add || cls == Sub) && !immSel) || cls == And || cls == Or)
            dstSel = fieldA;
        else if (cls == Not)
            dstSel = fieldB;  // not works in place on bits 1..0
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            opClass   <= Nop;
            laneMode  <= Half;
            immForm   <= 1'b0;
            writesReg <= 1'b0;
        end
        else if (decodeStrobe)
        begin
            opClass   <= cls;
            laneMode  <= laneMode_t'(offset[1:0]);
            immForm   <= immSel;
            writesReg <= cls inside {Add, Sub, And, Or, Not, Set, Load};
        end
    end

    always_ff @(posedge clk)
    begin
        if (decodeStrobe)
        begin
            dstIdx <= dstSel;
            srcIdx <= srcSel;
            imm    <= instructionIn[$bits(immField_t)-1:0];
        end
    end

endmodule

// ==== hw/simdIsaPkg.sv ====
package simdIsaPkg;

    typedef logic [17:0] instrWord_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [9:0]  immField_t;

    // family bases, +0/+1/+2 picks half, octet, quad
    localparam opcode_t OpAddRegBase = 6'd0;
    localparam opcode_t OpAddImmBase = 6'd3;
    localparam opcode_t OpSubRegBase = 6'd6;
    localparam opcode_t OpSubImmBase = 6'd9;
    localparam opcode_t OpAndBase    = 6'd27;
    localparam opcode_t OpOrBase     = 6'd30;
    localparam opcode_t OpNotBase    = 6'd33;
    localparam opcode_t OpLoopJump   = 6'd36;
    localparam opcode_t OpSetLoop    = 6'd37;
    localparam opcode_t OpLoadBase   = 6'd38;
    localparam opcode_t OpStoreBase  = 6'd41;
    localparam opcode_t OpSetBase    = 6'd44;
    localparam opcode_t OpHalt       = 6'd63;

    // field positions in the instruction word
    localparam int OpcodePos = 12;
    localparam int DstHiPos  = 10;  // reg of imm, set, load, store
    localparam int SrcAPos   = 2;
    localparam int SrcBPos   = 0;

    typedef enum logic [3:0] {
        Nop,
        Add,
        Sub,
        And,
        Or,
        Not,
        Set,
        Load,
        Store,
        LoopJump,
        SetLoop,
        Halt
    } opClass_t;

endpackage

// ==== hw/simdRegFiles.sv ====
`timescale 1ns/1ns

module simdRegFiles (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   execStrobe,
    input  logic                   wbStrobe,
    input  simdIsaPkg::opClass_t   opClass,
    input  simdDataPkg::laneMode_t laneMode,
    input  logic                   writesReg,
    input  simdDataPkg::regIdx_t   dstIdx,
    input  simdDataPkg::regIdx_t   srcIdx,
    input  simdDataPkg::dataWord_t aluResult,
    input  simdDataPkg::dataWord_t dataIn,
    output simdDataPkg::dataWord_t dstData,
    output simdDataPkg::dataWord_t srcData,
    output simdDataPkg::dataWord_t dataOut
);
    import simdIsaPkg::*;
    import simdDataPkg::*;

    // half, octet, quad banks, indexed by lane mode
    dataWord_t bank [NumBanks][NumRegs];
    dataWord_t resultReg;

    assign dstData = bank[laneMode][dstIdx];
    assign srcData = bank[laneMode][srcIdx];
    assign dataOut = resultReg;

    always_ff @(posedge clk)
    begin
        if (execStrobe)
            resultReg <= aluResult;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int b = 0; b < NumBanks; b++)
            begin
                for (int r = 0; r < NumRegs; r++)
                    bank[b][r] <= '0;
            end
        end
        else if (wbStrobe && writesReg)
        begin
            if (opClass == Load)
                bank[laneMode][dstIdx] <= dataIn;  // memory answers in writeback
            else
                bank[laneMode][dstIdx] <= resultReg;
        end
    end

endmodule

// ==== hw/simdSequencer.sv ====
`timescale 1ns/1ns

module simdSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  simdIsaPkg::opClass_t  opClass,
    input  simdIsaPkg::immField_t imm,
    output logic                  decodeStrobe,
    output logic                  execStrobe,
    output logic                  wbStrobe,
    output simdDataPkg::memAddr_t instructionAddress,
    output simdDataPkg::memAddr_t dataAddress,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic                  done
);
    import simdIsaPkg::*;
    import simdDataPkg::*;

    seqState_t state;
    seqState_t nextState;
    memAddr_t  pc;
    memAddr_t  nextPc;
    immField_t loopCount;
    logic      takeJump;

    assign decodeStrobe       = (state == Decode);
    assign execStrobe         = (state == Execute);
    assign wbStrobe           = (state == Writeback);
    assign done               = (state == Halted);
    assign instructionAddress = pc;
    assign takeJump           = (opClass == LoopJump) && (loopCount != '0);

    always_comb
    begin
        case (state)
            Idle:      nextState = Fetch;
            Fetch:     nextState = Decode;
            Decode:    nextState = Execute;
            Execute:   nextState = (opClass == Halt) ? Halted : Memory;  // halt seen in ID
            Memory:    nextState = Writeback;
            Writeback: nextState = Fetch;
            default:   nextState = state;  // halted until reset
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= Idle;
        else
            state <= nextState;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= '0;
            loopCount <= '0;
        end
        else if (state == Execute)
        begin
            if (opClass == SetLoop)
                loopCount <= imm;
            else if (takeJump)
                loopCount <= loopCount - 1'b1;
        end
        else if (state == Writeback)
            pc <= nextPc;
    end

    always_ff @(posedge clk)
    begin
        if (state == Execute)
        begin
            nextPc <= takeJump ? memAddr_t'(imm) : pc + 1'b1;
            if (opClass == Load || opClass == Store)
                dataAddress <= memAddr_t'(imm);
        end
    end

    // load reads through mem and wb, store writes in mem only
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dataRead  <= 1'b0;
            dataWrite <= 1'b0;
        end
        else
        begin
            case (state)
                Execute:
                begin
                    dataRead  <= (opClass == Load);
                    dataWrite <= (opClass == Store);
                end
                Memory:    dataWrite <= 1'b0;
                Writeback: dataRead <= 1'b0;
                default:   dataWrite <= 1'b0;
            endcase
        end
    end

endmodule

// ==== sim.f ====
hw/simdIsaPkg.sv
hw/simdDataPkg.sv
hw/simdDecode.sv
hw/laneAlu.sv
hw/simdRegFiles.sv
hw/simdSequencer.sv
hw/simdCore.sv
tb/simdCoreTb.sv

// ==== tb/simdCoreTb.sv ====
`timescale 1ns/1ns

module simdCoreTb;
    import simdIsaPkg::*;
    import simdDataPkg::*;

    localparam int MemWords    = 1024;
    localparam int LoopAddr    = 100;  // every loop pass stores here
    localparam int DoneTimeout = 4000;
    localparam int RefMaxSteps = 5000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    instrWord_t instructionIn = '0;
    dataWord_t  dataIn = '0;
    dataWord_t  dataOut;
    memAddr_t   instructionAddress;
    memAddr_t   dataAddress;
    logic       dataRead;
    logic       dataWrite;
    logic       done;

    instrWord_t rom [MemWords];
    dataWord_t  mem [MemWords];
    dataWord_t  refMem [MemWords];
    memAddr_t   expAddr [$];
    dataWord_t  expData [$];
    memAddr_t   expLoad [$];

    int        seed = 5;
    int        progLen;
    int        nextStore;
    int        loopCount;
    int        loopStart;
    int        loadCount;
    int        valueErrors = 0;
    int        otherErrors = 0;
    int        storesChecked = 0;
    int        loopStores = 0;
    int        readCycles = 0;
    int        cycles;
    logic      prevRead = 1'b0;
    memAddr_t  wantAddr;
    dataWord_t wantData;
    memAddr_t  haltPc;

    simdCore simdCore_i (
        .clk                (clk),
        .rst                (rst),
        .instructionIn      (instructionIn),
        .dataIn             (dataIn),
        .dataOut            (dataOut),
        .instructionAddress (instructionAddress),
        .dataAddress        (dataAddress),
        .dataRead           (dataRead),
        .dataWrite          (dataWrite),
        .done               (done)
    );

    always #5 clk = ~clk;

    // rom and data memory answer one edge after the address
    always @(posedge clk)
    begin
        instructionIn <= rom[instructionAddress];
        dataIn        <= mem[dataAddress];
        if (dataWrite === 1'b1)
            mem[dataAddress] = dataOut;
    end

    function automatic instrWord_t encode(int op, int hi, int low);
        return {6'(op), 2'(hi), 10'(low)};
    endfunction

    function automatic void appendInstr(int op, int hi, int low);
        rom[progLen] = encode(op, hi, low);
        progLen++;
    endfunction

    function automatic void storeReg(int mode, int r);
        appendInstr(OpStoreBase + mode, r, nextStore);
        nextStore++;
    endfunction

    function automatic int randImm();
        return $random(seed) & 32'h3ff;
    endfunction

    function automatic dataWord_t widenImm(int imm, int mode);
        logic [9:0] v;
        v = 10'(imm);
        if (mode == 1)
            return {v[7:0], v[7:0]};
        if (mode == 2)
            return {4{v[3:0]}};
        return {6'b0, v};
    endfunction

    // lane-wise add or subtract, each lane wraps on its own
    function automatic dataWord_t laneArith(dataWord_t a, dataWord_t b, int mode, bit sub);
        int width;
        int mask;
        int x;
        int result;
        width  = 16 >> mode;
        mask   = (1 << width) - 1;
        result = 0;
        for (int l = 0; l < 16 / width; l++)
        begin
            if (sub)
                x = ((a >> (l * width)) & mask) - ((b >> (l * width)) & mask);
            else
                x = ((a >> (l * width)) & mask) + ((b >> (l * width)) & mask);
            result = result | ((x & mask) << (l * width));
        end
        return 16'(result);
    endfunction

    function automatic void buildProgram();
        int addr;
        for (int i = 0; i < MemWords; i++)
        begin
            rom[i] = encode(OpHalt, 0, 0);
            mem[i] = 16'($random(seed));
        end
        progLen   = 0;
        nextStore = 16;
        loadCount = 0;
        for (int m = 0; m < 3; m++)
        begin
            appendInstr(OpSetBase + m, 0, randImm());
            appendInstr(OpSetBase + m, 1, randImm());
            appendInstr(OpAddImmBase + m, 0, randImm());
            appendInstr(OpSubImmBase + m, 1, randImm());
            appendInstr(OpAddRegBase + m, 0, 4 * 0 + 1);  // r0 += r1
            appendInstr(OpSubRegBase + m, 0, 4 * 1 + 0);  // r1 -= r0
            storeReg(m, 0);
            storeReg(m, 1);
        end
        for (int m = 0; m < 3; m++)
        begin
            appendInstr(OpSetBase + m, 2, randImm());
            appendInstr(OpSetBase + m, 3, randImm());
            appendInstr(OpAndBase + m, 0, 4 * 2 + 3);
            storeReg(m, 2);
            appendInstr(OpSetBase + m, 2, randImm());
            appendInstr(OpOrBase + m, 0, 4 * 2 + 3);
            storeReg(m, 2);
            appendInstr(OpNotBase + m, 0, 3);
            storeReg(m, 3);
        end
        for (int m = 0; m < 3; m++)
        begin
            addr = 512 + ($random(seed) & 511);  // upper half is never stored to
            appendInstr(OpLoadBase + m, 1, addr);
            appendInstr(OpAddImmBase + m, 1, randImm());
            storeReg(m, 1);
            loadCount++;
        end
        appendInstr(20, 0, 0);  // dropped multiply opcode
        loopCount = 2 + ($random(seed) & 3);
        appendInstr(OpSetLoop, 0, loopCount);
        loopStart = progLen;
        appendInstr(OpAddImmBase + 2, 0, randImm());
        appendInstr(OpStoreBase + 2, 0, LoopAddr);
        appendInstr(OpLoopJump, 0, loopStart);
        appendInstr(OpHalt, 0, 0);
    endfunction

    // walks the rom with the ISA rules, fills refMem and the expected queues
    function automatic void runReference();
        dataWord_t  bank [3][4];
        instrWord_t w;
        int         pc;
        int         nextPc;
        int         loopCnt;
        int         op;
        int         m;
        int         kind;
        int         hi;
        int         ra;
        int         rb;
        int         imm;
        bit         running;
        for (int i = 0; i < MemWords; i++)
            refMem[i] = mem[i];
        for (int b = 0; b < 3; b++)
        begin
            for (int r = 0; r < 4; r++)
                bank[b][r] = '0;
        end
        pc      = 0;
        loopCnt = 0;
        running = 1'b1;
        for (int step = 0; step < RefMaxSteps && running; step++)
        begin
            w      = rom[pc];
            op     = w[17:12];
            hi     = w[11:10];
            ra     = w[3:2];
            rb     = w[1:0];
            imm    = w[9:0];
            nextPc = (pc + 1) % MemWords;
            if (op <= OpSubImmBase + 2)
            begin
                m = op % 3;
                if ((op / 3) % 2 == 1)  // immediate forms
                    bank[m][hi] = laneArith(bank[m][hi], widenImm(imm, m), m, op >= OpSubRegBase);
                else
                    bank[m][ra] = laneArith(bank[m][ra], bank[m][rb], m, op >= OpSubRegBase);
            end
            else if (op >= OpAndBase && op <= OpNotBase + 2)
            begin
                m    = (op - OpAndBase) % 3;
                kind = (op - OpAndBase) / 3;
                if (kind == 0)
                    bank[m][ra] = bank[m][ra] & bank[m][rb];
                else if (kind == 1)
                    bank[m][ra] = bank[m][ra] | bank[m][rb];
                else
                    bank[m][rb] = ~bank[m][rb];
            end
            else if (op == OpLoopJump)
            begin
                if (loopCnt != 0)
                begin
                    nextPc = imm;
                    loopCnt--;
                end
            end
            else if (op == OpSetLoop)
                loopCnt = imm;
            else if (op >= OpLoadBase && op <= OpSetBase + 2)
            begin
                m    = (op - OpLoadBase) % 3;
                kind = (op - OpLoadBase) / 3;
                if (kind == 0)
                begin
                    bank[m][hi] = refMem[imm];
                    expLoad.push_back(10'(imm));
                end
                else if (kind == 1)
                begin
                    refMem[imm] = bank[m][hi];
                    expAddr.push_back(10'(imm));
                    expData.push_back(bank[m][hi]);
                end
                else
                    bank[m][hi] = widenImm(imm, m);
            end
            else if (op == OpHalt)
                running = 1'b0;
            if (running)
                pc = nextPc;
        end
    endfunction

    task automatic reportMismatch(string name, logic [15:0] got, logic [15:0] want);
        valueErrors++;
        $display("** Error %s: got %h, expected %h", name, got, want);
    endtask

    // compares every store and load against the reference
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (dataWrite === 1'b1)
            begin
                if (dataAddress === LoopAddr)
                    loopStores++;
                if (expAddr.size() == 0)
                begin
                    otherErrors++;
                    $display("store to address %h when no store was expected", dataAddress);
                end
                else
                begin
                    wantAddr = expAddr.pop_front();
                    wantData = expData.pop_front();
                    storesChecked++;
                    if (dataAddress !== wantAddr)
                        reportMismatch("dataAddress", dataAddress, wantAddr);
                    if (dataOut !== wantData)
                        reportMismatch("dataOut", dataOut, wantData);
                end
            end
            if (dataRead === 1'b1)
            begin
                readCycles++;
                if (!prevRead && expLoad.size() == 0)
                begin
                    otherErrors++;
                    $display("load from address %h when no load was expected", dataAddress);
                end
                else if (!prevRead)
                begin
                    wantAddr = expLoad.pop_front();
                    if (dataAddress !== wantAddr)
                        reportMismatch("dataAddress", dataAddress, wantAddr);
                end
            end
            if (dataRead === 1'b1 && dataWrite === 1'b1)
            begin
                otherErrors++;
                $display("dataRead and dataWrite are high in the same cycle");
            end
            prevRead = (dataRead === 1'b1);
        end
    end

    initial
    begin
        buildProgram();
        runReference();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (done !== 1'b0)
            reportMismatch("done", done, 0);
        if (dataRead !== 1'b0)
            reportMismatch("dataRead", dataRead, 0);
        if (dataWrite !== 1'b0)
            reportMismatch("dataWrite", dataWrite, 0);
        if (instructionAddress !== '0)
            reportMismatch("instructionAddress", instructionAddress, 0);

        cycles = 0;
        while (done !== 1'b1 && cycles < DoneTimeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            otherErrors++;
            $display("timeout: done not raised within %0d cycles", DoneTimeout);
        end
        else
        begin
            haltPc = instructionAddress;
            if (haltPc !== 10'(progLen - 1))
                reportMismatch("instructionAddress", haltPc, 16'(progLen - 1));
            for (int i = 0; i < 20; i++)  // halted machine must stay put
            begin
                @(negedge clk);
                if (done !== 1'b1)
                    reportMismatch("done", done, 1);
                if (instructionAddress !== haltPc)
                    reportMismatch("instructionAddress", instructionAddress, haltPc);
            end
            for (int i = 0; i < MemWords; i++)
            begin
                if (mem[i] !== refMem[i])
                begin
                    valueErrors++;
                    $display("** Error mem[%h]: got %h, expected %h", 10'(i), mem[i], refMem[i]);
                end
            end
            if (expAddr.size() != 0 || expLoad.size() != 0)
            begin
                otherErrors++;
                $display("%0d stores and %0d loads never happened", expAddr.size(), expLoad.size());
            end
            if (loopStores != loopCount + 1)
            begin
                otherErrors++;
                $display("loop stored %0d times instead of %0d", loopStores, loopCount + 1);
            end
            if (readCycles != 2 * loadCount)
            begin
                otherErrors++;
                $display("dataRead high for %0d cycles, loads need %0d", readCycles, 2 * loadCount);
            end
        end

        $display("stores checked %0d, value errors %0d, other errors %0d",
            storesChecked, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
